// File: ac97_params.svh
`ifndef AC97_PARAMS_SVH
`define AC97_PARAMS_SVH

// serial frame layout, in bit clocks
`define AC97_FRAME_BITS 256
`define AC97_SYNC_BITS 16
// engine ready level window, rises at 128 and falls at 2
`define AC97_READY_SET_BIT 128
`define AC97_READY_CLR_BIT 2

// first bit of each slot after the tag slot
`define AC97_SLOT1_START 16
`define AC97_SLOT2_START 36
`define AC97_SLOT3_START 56
`define AC97_SLOT4_START 76
`define AC97_SLOT_BITS 20

// board level timing and defaults
`define AC97_CODEC_RESET_CYCLES 1023
`define AC97_DEBOUNCE_CYCLES 270000
`define AC97_VOLUME_DEFAULT 8
`define AC97_VOLUME_MAX 31

`endif

// File: ac97_pkg.sv
package ac97_pkg;

  // pcm payloads
  typedef logic [19:0] sample_t;
  typedef logic [7:0] pcm8_t;
  typedef logic [4:0] volume_t;

  // codec command fields
  typedef logic [7:0] cmd_addr_t;
  typedef logic [15:0] cmd_data_t;

  // codec register map, only the ones we touch
  typedef enum logic [7:0] {
    reg_headphone_vol   = 8'h04,
    reg_beep_vol        = 8'h0A,
    reg_mic_gain        = 8'h0E,
    reg_pcm_vol         = 8'h18,
    reg_record_select   = 8'h1A,
    reg_record_gain     = 8'h1C,
    reg_general_purpose = 8'h20,
    reg_read_id         = 8'h80
  } ac97_reg_e;

  // sixteen sequencer steps, unnamed slots just read the id
  typedef enum logic [3:0] {
    step_id_0, step_id_1, step_id_2, step_headphone,
    step_id_4, step_pcm, step_record_select, step_record_gain,
    step_id_8, step_mic_gain, step_beep, step_general,
    step_id_c, step_id_d, step_id_e, step_id_f
  } cmd_step_e;

endpackage

// File: ac97_frame_if.sv
`timescale 1ns/1ns

interface ac97_frame_if import ac97_pkg::*; ();

  // command slots, written by the sequencer
  cmd_addr_t command_address;
  cmd_data_t command_data;
  logic command_valid;

  // pcm slots, out from the link, in from the engine
  sample_t left_out;
  sample_t right_out;
  sample_t left_in;

  modport seq_mp (output command_address, command_data, command_valid);

  modport link_mp (output left_out, right_out, input left_in);

  // engine samples everything at the end of the frame
  modport engine_mp (
    input command_address, command_data, command_valid, left_out, right_out,
    output left_in
  );

endinterface

// File: switch_debounce.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module switch_debounce #(
  parameter int unsigned debounce_cycles = `AC97_DEBOUNCE_CYCLES
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // wide enough to hold debounce_cycles, even for zero
  localparam int count_w = $clog2(debounce_cycles + 2);
  localparam logic [count_w-1:0] count_done = count_w'(debounce_cycles);

  logic [count_w-1:0] count;
  logic sampled;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      sampled <= noisy;
      clean <= noisy;
    end else if (noisy != sampled) begin
      // input moved, start over
      sampled <= noisy;
      count <= '0;
    end else if (count == count_done) begin
      // stable long enough
      clean <= sampled;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: volume_control.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module volume_control import ac97_pkg::*; #(
  parameter int unsigned debounce_cycles = `AC97_DEBOUNCE_CYCLES
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  output volume_t volume
);

  localparam volume_t vol_default = volume_t'(`AC97_VOLUME_DEFAULT);
  localparam volume_t vol_max = volume_t'(`AC97_VOLUME_MAX);

  logic up_clean, down_clean;
  logic up_last, down_last;
  logic up_press, down_press;

  // buttons are active low on the board
  switch_debounce #(.debounce_cycles(debounce_cycles)) u_debounce_up (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(~button_up),
    .clean(up_clean)
  );

  switch_debounce #(.debounce_cycles(debounce_cycles)) u_debounce_down (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(~button_down),
    .clean(down_clean)
  );

  // rising edge of each debounced level
  assign up_press = up_clean & ~up_last;
  assign down_press = down_clean & ~down_last;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      volume <= vol_default;
      up_last <= 1'b0;
      down_last <= 1'b0;
    end else begin
      up_last <= up_clean;
      down_last <= down_clean;
      // saturate at both ends, down assigned last so it wins a tie
      if (up_press && volume != vol_max)
        volume <= volume + 1'b1;
      if (down_press && volume != '0)
        volume <= volume - 1'b1;
    end
  end

endmodule

// File: codec_command_seq.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module codec_command_seq import ac97_pkg::*; (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic ready,
  input  volume_t volume,
  ac97_frame_if.seq_mp frame
);

  cmd_step_e step;
  volume_t atten;

  // codec wants attenuation, not gain
  assign atten = volume_t'(`AC97_VOLUME_MAX) - volume;

  // one step per frame, wraps at 16
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      step <= step_id_0;
      frame.command_valid <= 1'b0;
    end else begin
      if (ready)
        step <= cmd_step_e'(step + 4'd1);
      // valid from the first step onward
      if (step == step_id_0)
        frame.command_valid <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // command register, follows the step one cycle later
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    case (step)
      step_headphone: begin
        frame.command_address <= reg_headphone_vol;
        frame.command_data <= {3'b000, atten, 3'b000, atten};
      end
      step_pcm: begin
        frame.command_address <= reg_pcm_vol;
        frame.command_data <= 16'h0808;
      end
      step_record_select: begin
        // microphone on both channels
        frame.command_address <= reg_record_select;
        frame.command_data <= 16'h0000;
      end
      step_record_gain: begin
        frame.command_address <= reg_record_gain;
        frame.command_data <= 16'h0F0F;
      end
      step_mic_gain: begin
        // +20 dB boost
        frame.command_address <= reg_mic_gain;
        frame.command_data <= 16'h8048;
      end
      step_beep: begin
        frame.command_address <= reg_beep_vol;
        frame.command_data <= 16'h0000;
      end
      step_general: begin
        // pcm out bypasses the 3d mix
        frame.command_address <= reg_general_purpose;
        frame.command_data <= 16'h8000;
      end
      default: begin
        frame.command_address <= reg_read_id;
        frame.command_data <= 16'h0000;
      end
    endcase
  end

endmodule

// File: ac97_frame_engine.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module ac97_frame_engine import ac97_pkg::*; (
  input  logic ac97_bit_clock,
  input  logic reset,
  output logic ready,
  ac97_frame_if.engine_mp frame,
  output logic sdata_out,
  input  logic sdata_in,
  output logic synch
);

  localparam logic [7:0] last_bit = 8'(`AC97_FRAME_BITS - 1);
  localparam logic [7:0] sync_last = 8'(`AC97_SYNC_BITS - 1);
  localparam logic [7:0] ready_set = 8'(`AC97_READY_SET_BIT);
  localparam logic [7:0] ready_clr = 8'(`AC97_READY_CLR_BIT);
  localparam logic [7:0] slot1 = 8'(`AC97_SLOT1_START);
  localparam logic [7:0] slot2 = 8'(`AC97_SLOT2_START);
  localparam logic [7:0] slot3 = 8'(`AC97_SLOT3_START);
  localparam logic [7:0] slot4 = 8'(`AC97_SLOT4_START);
  localparam logic [7:0] slot_end = 8'(`AC97_SLOT4_START + `AC97_SLOT_BITS);

  logic reset_meta, reset_sync;
  logic [7:0] bit_count;
  logic cmd_valid_l, pcm_valid_l;
  sample_t addr_shift, data_shift, left_shift, right_shift;

  // bring reset into the bit clock domain
  always_ff @(posedge ac97_bit_clock) begin
    reset_meta <= reset;
    reset_sync <= reset_meta;
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame timing and serial out, rising edge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (reset_sync) begin
      bit_count <= '0;
      synch <= 1'b0;
      ready <= 1'b0;
      sdata_out <= 1'b0;
      cmd_valid_l <= 1'b0;
      pcm_valid_l <= 1'b0;
    end else begin
      bit_count <= bit_count + 8'd1;
      if (bit_count == last_bit)
        synch <= 1'b1;
      else if (bit_count == sync_last)
        synch <= 1'b0;
      // ready spans the quiet tail of the frame
      if (bit_count == ready_set)
        ready <= 1'b1;
      else if (bit_count == ready_clr)
        ready <= 1'b0;
      // tags latched with the payload, so frame 0 goes out empty
      if (bit_count == last_bit) begin
        cmd_valid_l <= frame.command_valid;
        pcm_valid_l <= 1'b1;
      end
      if (bit_count < slot1) begin
        // tag slot
        case (bit_count[3:0])
          4'h0: sdata_out <= 1'b1;
          4'h1, 4'h2: sdata_out <= cmd_valid_l;
          4'h3, 4'h4: sdata_out <= pcm_valid_l;
          default: sdata_out <= 1'b0;
        endcase
      end else if (bit_count < slot2)
        sdata_out <= cmd_valid_l & addr_shift[19];
      else if (bit_count < slot3)
        sdata_out <= cmd_valid_l & data_shift[19];
      else if (bit_count < slot4)
        sdata_out <= pcm_valid_l & left_shift[19];
      else if (bit_count < slot_end)
        sdata_out <= pcm_valid_l & right_shift[19];
      else
        sdata_out <= 1'b0;
    end
  end

  // payload load at frame end, msb first shifting per slot
  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == last_bit) begin
      addr_shift <= {frame.command_address, 12'h000};
      data_shift <= {frame.command_data, 4'h0};
      left_shift <= frame.left_out;
      right_shift <= frame.right_out;
    end else if (bit_count >= slot1 && bit_count < slot2)
      addr_shift <= {addr_shift[18:0], 1'b0};
    else if (bit_count >= slot2 && bit_count < slot3)
      data_shift <= {data_shift[18:0], 1'b0};
    else if (bit_count >= slot3 && bit_count < slot4)
      left_shift <= {left_shift[18:0], 1'b0};
    else if (bit_count >= slot4 && bit_count < slot_end)
      right_shift <= {right_shift[18:0], 1'b0};
  end

  // slot 3 in, sampled on the falling edge
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count > slot3 && bit_count <= slot4)
      frame.left_in <= {frame.left_in[18:0], sdata_in};
  end

endmodule

// File: ac97_link.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module ac97_link import ac97_pkg::*; (
  input  logic clock_27mhz,
  input  logic reset,
  input  volume_t volume,
  output logic audio_reset_b,
  output logic ac97_sdata_out,
  input  logic ac97_sdata_in,
  output logic ac97_synch,
  input  logic ac97_bit_clock
);

  localparam int reset_w = $clog2(`AC97_CODEC_RESET_CYCLES + 1);
  localparam logic [reset_w-1:0] reset_last = reset_w'(`AC97_CODEC_RESET_CYCLES);

  logic [reset_w-1:0] reset_count;
  logic engine_ready;
  logic [2:0] ready_sync;
  logic ready;
  pcm8_t loop_sample;

  ac97_frame_if u_frame ();

  // hold the codec in reset for a while
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      reset_count <= '0;
      audio_reset_b <= 1'b0;
    end else if (reset_count == reset_last)
      audio_reset_b <= 1'b1;
    else
      reset_count <= reset_count + 1'b1;
  end

  // ready level crosses from bit clock, pulse on its rise
  always_ff @(posedge clock_27mhz) begin
    if (reset)
      ready_sync <= '0;
    else
      ready_sync <= {ready_sync[1:0], engine_ready};
  end

  assign ready = ready_sync[1] & ~ready_sync[2];

  // mono loopback, top byte of left in goes to both outputs
  always_ff @(posedge clock_27mhz) begin
    if (ready)
      loop_sample <= u_frame.left_in[19:12];
  end

  assign u_frame.left_out = {loop_sample, 12'h000};
  assign u_frame.right_out = {loop_sample, 12'h000};

  ac97_frame_engine u_engine (
    .ac97_bit_clock(ac97_bit_clock),
    .reset(reset),
    .ready(engine_ready),
    .frame(u_frame.engine_mp),
    .sdata_out(ac97_sdata_out),
    .sdata_in(ac97_sdata_in),
    .synch(ac97_synch)
  );

  codec_command_seq u_seq (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .ready(ready),
    .volume(volume),
    .frame(u_frame.seq_mp)
  );

endmodule

// File: ac97_audio_top.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module ac97_audio_top import ac97_pkg::*; #(
  parameter int unsigned debounce_cycles = `AC97_DEBOUNCE_CYCLES
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  output logic audio_reset_b,
  output logic ac97_sdata_out,
  input  logic ac97_sdata_in,
  output logic ac97_synch,
  input  logic ac97_bit_clock
);

  volume_t volume;

  // push buttons step the headphone level
  volume_control #(.debounce_cycles(debounce_cycles)) u_volume_control (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  // codec reset, command list and serial frames
  ac97_link u_ac97_link (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .volume(volume),
    .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in),
    .ac97_synch(ac97_synch),
    .ac97_bit_clock(ac97_bit_clock)
  );

endmodule

// File: ac97_codec_model.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module ac97_codec_model import ac97_pkg::*; #(
  parameter int half_period = 40,
  parameter logic [31:0] seed = 32'h8def
) (
  output logic ac97_bit_clock,
  input  logic ac97_synch,
  input  logic ac97_sdata_out,
  output logic ac97_sdata_in
);

  // per frame record, frame n lands at n modulo 1024
  logic [15:0] tag_mem [1024];
  sample_t slot1_mem [1024];
  sample_t slot2_mem [1024];
  sample_t slot3_mem [1024];
  sample_t slot4_mem [1024];
  sample_t sent_mem [1024];
  int length_mem [1024];
  int synch_mem [1024];
  int frame_count;

  logic [31:0] lfsr;
  logic started;
  logic synch_last;
  int bit_index;
  int synch_width;
  int slot_sel;
  logic [15:0] tag_shift;
  sample_t slot_shift [4];
  sample_t tx_sample;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  // one lfsr step per sample bit, msb drawn first
  task automatic draw_sample(output sample_t sample);
    sample = '0;
    for (int i = 0; i < `AC97_SLOT_BITS; i++) begin
      sample = {sample[18:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  initial begin
    ac97_bit_clock = 1'b0;
    ac97_sdata_in = 1'b0;
    lfsr = seed;
    started = 1'b0;
    synch_last = 1'b0;
    frame_count = 0;
    bit_index = 0;
    synch_width = 0;
    tx_sample = '0;
    forever #(half_period) ac97_bit_clock = ~ac97_bit_clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // controller to codec, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge ac97_bit_clock) begin
    if (ac97_synch === 1'b1 && synch_last !== 1'b1) begin
      // synch rise closes the last frame, this edge still holds bit 255
      if (started) begin
        tag_mem[frame_count[9:0]] = tag_shift;
        slot1_mem[frame_count[9:0]] = slot_shift[0];
        slot2_mem[frame_count[9:0]] = slot_shift[1];
        slot3_mem[frame_count[9:0]] = slot_shift[2];
        slot4_mem[frame_count[9:0]] = slot_shift[3];
        sent_mem[frame_count[9:0]] = tx_sample;
        length_mem[frame_count[9:0]] = bit_index + 1;
        synch_mem[frame_count[9:0]] = synch_width;
        // count last, so a reader never sees a half written record
        frame_count = frame_count + 1;
      end
      started = 1'b1;
      bit_index = 0;
      synch_width = 1;
      draw_sample(tx_sample);
    end else if (started) begin
      if (ac97_synch === 1'b1)
        synch_width = synch_width + 1;
      if (bit_index < `AC97_SLOT1_START) begin
        tag_shift = {tag_shift[14:0], ac97_sdata_out};
      end else if (bit_index < `AC97_SLOT4_START + `AC97_SLOT_BITS) begin
        // slots 1 to 4, msb first
        slot_sel = (bit_index - `AC97_SLOT1_START) / `AC97_SLOT_BITS;
        slot_shift[slot_sel] = {slot_shift[slot_sel][18:0], ac97_sdata_out};
      end
      bit_index = bit_index + 1;
    end
    synch_last = ac97_synch;
  end

  // slot 3 back to the controller, driven on the rising edge
  always @(posedge ac97_bit_clock) begin
    if (started && bit_index >= `AC97_SLOT3_START && bit_index < `AC97_SLOT4_START)
      ac97_sdata_in <= tx_sample[`AC97_SLOT4_START - 1 - bit_index];
    else
      ac97_sdata_in <= 1'b0;
  end

endmodule

// File: tb_ac97_audio_top.sv
`timescale 1ns/1ns
`include "ac97_params.svh"

module tb_ac97_audio_top import ac97_pkg::*;;

  localparam int clock_half_period = 20;
  localparam int bit_half_period = 40;
  localparam logic [31:0] lfsr_seed = 32'h8def;
  localparam int debounce = 16;
  localparam int press_cycles = 40;
  // clock_27mhz cycles per serial frame
  localparam int frame_cycles = bit_half_period * `AC97_FRAME_BITS / clock_half_period;
  localparam int rows = 6;

  // up presses, down presses, volume after the row
  int up_presses [rows] = '{0, 3, 25, 0, 0, 2};
  int down_presses [rows] = '{0, 0, 0, 5, 30, 0};
  int expected_volume [rows] = '{8, 11, 31, 26, 0, 2};

  logic clock_27mhz;
  logic reset;
  logic button_up;
  logic button_down;
  logic audio_reset_b;
  logic ac97_sdata_out;
  logic ac97_sdata_in;
  logic ac97_synch;
  logic ac97_bit_clock;

  int errors;
  int tests;
  int failed_tests;

  ac97_audio_top #(.debounce_cycles(debounce)) u_ac97_audio_top (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in),
    .ac97_synch(ac97_synch),
    .ac97_bit_clock(ac97_bit_clock)
  );

  // codec side, owns the bit clock
  ac97_codec_model #(.half_period(bit_half_period), .seed(lfsr_seed)) u_codec (
    .ac97_bit_clock(ac97_bit_clock),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

  initial begin
    clock_27mhz = 1'b0;
    forever #(clock_half_period) clock_27mhz = ~clock_27mhz;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got == want) else begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: pass", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: fail, %0d errors", tests, name, errors - errors_before);
    end
  endtask

  // address and data the codec should get for a step
  function automatic logic [23:0] expected_command(input int step, input int vol);
    logic [4:0] atten;
    atten = 5'(`AC97_VOLUME_MAX - vol);
    case (cmd_step_e'(step))
      step_headphone: return {8'h04, 3'b000, atten, 3'b000, atten};
      step_pcm: return {8'h18, 16'h0808};
      step_record_select: return {8'h1A, 16'h0000};
      step_record_gain: return {8'h1C, 16'h0F0F};
      step_mic_gain: return {8'h0E, 16'h8048};
      step_beep: return {8'h0A, 16'h0000};
      step_general: return {8'h20, 16'h8000};
      default: return {8'h80, 16'h0000};
    endcase
  endfunction

  task automatic wait_frame_count(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit = (target - u_codec.frame_count + 2) * frame_cycles;
    while (u_codec.frame_count < target && cycles < limit) begin
      @(negedge clock_27mhz);
      cycles++;
    end
    if (u_codec.frame_count < target) begin
      $display("timeout: codec model saw %0d of %0d frames", u_codec.frame_count, target);
      errors++;
    end
  endtask

  // first frame from index first on that writes the headphone register
  task automatic find_headphone(input int first, output int found);
    int scan;
    int cycles;
    scan = first;
    found = -1;
    cycles = 0;
    while (found < 0 && cycles < 19 * frame_cycles) begin
      @(negedge clock_27mhz);
      cycles++;
      if (scan < u_codec.frame_count) begin
        if (u_codec.slot1_mem[scan[9:0]][19:12] == 8'h04)
          found = scan;
        scan++;
      end
    end
    if (found < 0) begin
      $display("timeout: no headphone volume command seen after frame %0d", first);
      errors++;
    end
  endtask

  // buttons are active low, held well past the debounce count
  task automatic press(input logic up);
    @(posedge clock_27mhz);
    if (up)
      button_up <= 1'b0;
    else
      button_down <= 1'b0;
    repeat (press_cycles) @(posedge clock_27mhz);
    button_up <= 1'b1;
    button_down <= 1'b1;
    repeat (press_cycles) @(posedge clock_27mhz);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int errors_before;
    int head;
    int cycles;
    logic seen_high;
    logic [23:0] cmd;
    sample_t loop_want;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    reset = 1'b1;
    button_up = 1'b1;
    button_down = 1'b1;
    repeat (16) @(posedge clock_27mhz);
    reset <= 1'b0;

    // codec reset release
    errors_before = errors;
    seen_high = 1'b0;
    repeat (1000) begin
      @(negedge clock_27mhz);
      seen_high = seen_high | audio_reset_b;
    end
    check_value("audio_reset_b in first 1000 cycles", 32'(seen_high), 0);
    cycles = 0;
    while (audio_reset_b !== 1'b1 && cycles < 30) begin
      @(negedge clock_27mhz);
      cycles++;
    end
    assert (audio_reset_b === 1'b1) else begin
      $display("audio_reset_b was still low 1030 cycles after reset");
      errors++;
    end
    end_test("codec reset delay", errors_before);

    // synch width, frame length and tags
    errors_before = errors;
    wait_frame_count(40);
    for (int n = 1; n < 40; n++) begin
      check_value($sformatf("frame %0d length", n), u_codec.length_mem[n], `AC97_FRAME_BITS);
      check_value($sformatf("frame %0d ac97_synch width", n), u_codec.synch_mem[n],
                  `AC97_SYNC_BITS);
      check_value($sformatf("frame %0d tag slot", n), u_codec.tag_mem[n], 16'hF800);
    end
    end_test("frame timing and tags", errors_before);

    // sixteen frames walk the command list in order
    errors_before = errors;
    find_headphone(1, head);
    if (head >= 0) begin
      wait_frame_count(head + 16);
      for (int k = 0; k < 16; k++) begin
        cmd = expected_command((int'(step_headphone) + k) % 16, `AC97_VOLUME_DEFAULT);
        check_value($sformatf("frame %0d slot 1", head + k), u_codec.slot1_mem[head + k],
                    {cmd[23:16], 12'h000});
        check_value($sformatf("frame %0d slot 2", head + k), u_codec.slot2_mem[head + k],
                    {cmd[15:0], 4'h0});
      end
    end
    end_test("command list order", errors_before);

    // frame n input comes back in frame n+1 on both channels
    errors_before = errors;
    for (int n = 1; n < 39; n++) begin
      loop_want = {u_codec.sent_mem[n][19:12], 12'h000};
      check_value($sformatf("frame %0d slot 3", n + 1), u_codec.slot3_mem[n + 1], loop_want);
      check_value($sformatf("frame %0d slot 4", n + 1), u_codec.slot4_mem[n + 1], loop_want);
    end
    end_test("pcm loopback", errors_before);

    // volume table, checked through the headphone command
    for (int r = 0; r < rows; r++) begin
      errors_before = errors;
      for (int p = 0; p < up_presses[r]; p++)
        press(1'b1);
      for (int p = 0; p < down_presses[r]; p++)
        press(1'b0);
      // next frame is latched after the last press
      find_headphone(u_codec.frame_count + 1, head);
      if (head >= 0) begin
        cmd = expected_command(int'(step_headphone), expected_volume[r]);
        check_value($sformatf("row %0d headphone command_data", r),
                    u_codec.slot2_mem[head], {cmd[15:0], 4'h0});
      end
      end_test($sformatf("volume row %0d", r), errors_before);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests, tests - failed_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: ac97_audio_top.f
+incdir+.
ac97_pkg.sv
ac97_frame_if.sv
switch_debounce.sv
volume_control.sv
codec_command_seq.sv
ac97_frame_engine.sv
ac97_link.sv
ac97_audio_top.sv
ac97_codec_model.sv
tb_ac97_audio_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ac97 audio testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ac97_audio_top \
  -f ac97_audio_top.f \
  -o sim_ac97_audio_top
./obj_dir/sim_ac97_audio_top > sim.log 2>&1
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
